// File: dv/exu_checker.sv
// concurrent assertions on the writeback and jump outputs, bound into the top level
`timescale 1ns/1ps

module exu_checker (
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                issue_valid_i,
    input logic                issue_ready_i,
    input exu_bus_pkg::issue_t issue_i,
    input logic                wb_valid_i,
    input logic                wb_ready_i,
    input exu_bus_pkg::wb_t    wb_i,
    input logic                jump_valid_i
);
    // a stalled record stays put until taken
    wb_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (wb_valid_i && !wb_ready_i) |=> (wb_valid_i && $stable(wb_i)))
        else $error("wb_o changed or dropped while wb_ready_i was low");

    // a second pulse in a row needs a branch that entered two edges earlier
    jump_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (jump_valid_i && $past(jump_valid_i)) |->
            $past(issue_valid_i && issue_ready_i &&
                  (issue_i.unit == exu_op_pkg::UNIT_BRU), 2))
        else $error("jump_valid_o lasted two cycles for one branch");

    reset_quiet_a: assert property (@(posedge clk_i)
        !arst_n_i |-> (!wb_valid_i && !jump_valid_i))
        else $error("an output valid was high during reset");

endmodule

bind exu_top exu_checker u_checker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_valid_i(issue_valid_i),
    .issue_ready_i(issue_ready_o),
    .issue_i      (issue_i),
    .wb_valid_i   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_i         (wb_o),
    .jump_valid_i (jump_valid_o)
);

// File: dv/exu_tb.sv
// testbench top: clock, reset, random stimulus, reference model and compare tasks
`timescale 1ns/1ps

module exu_tb;
    localparam int NUM_ITEMS     = 400;
    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                issue_valid_i;
    logic                issue_ready_o;
    exu_bus_pkg::issue_t issue_i;
    logic                wb_valid_o;
    logic                wb_ready_i;
    exu_bus_pkg::wb_t    wb_o;
    logic                jump_valid_o;
    exu_bus_pkg::jump_t  jump_o;

    exu_bus_pkg::wb_t    wb_expected[$];
    exu_bus_pkg::jump_t  jump_expected[$];
    logic [63:0]         rng_state = 64'd33;

    exu_top dut_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .issue_valid_i(issue_valid_i),
        .issue_ready_o(issue_ready_o),
        .issue_i      (issue_i),
        .wb_valid_o   (wb_valid_o),
        .wb_ready_i   (wb_ready_i),
        .wb_o         (wb_o),
        .jump_valid_o (jump_valid_o),
        .jump_o       (jump_o)
    );

    always #20 clk_i = ~clk_i;

    // 64-bit lcg, upper half has the better bits
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state[63:32];
    endfunction

    // corner values show up often enough to hit div by zero and sign edges
    function automatic logic [31:0] pick_operand();
        logic [31:0] sel;
        logic [31:0] val;
        sel = next_random();
        val = next_random();
        case (sel[2:0])
            3'd0:    return 32'd0;
            3'd1:    return 32'hFFFF_FFFF;
            3'd2:    return 32'h8000_0000;
            3'd3:    return {28'd0, val[3:0]};
            3'd4:    return {{28{val[31]}}, val[3:0]};
            default: return val;
        endcase
    endfunction

    function automatic exu_bus_pkg::issue_t random_item(
        input logic [exu_bus_pkg::COMMIT_ID_W-1:0] cid
    );
        exu_bus_pkg::issue_t it;
        logic [31:0]         r;
        r            = next_random();
        it.rs1       = pick_operand();
        it.rs2       = pick_operand();
        it.pc        = next_random() & 32'hFFFF_FFFC;
        it.imm       = next_random() & 32'hFFFF_FFFE;
        it.rd        = r[4:0];
        it.commit_id = cid;
        case (r[23:16] % 3)
            8'd0: begin
                it.unit = exu_op_pkg::UNIT_ALU;
                it.op   = 4'(r[15:8] % 10);
            end
            8'd1: begin
                it.unit = exu_op_pkg::UNIT_BRU;
                it.op   = 4'(r[10:8]);
                // equal operands for beq, bge and bgeu
                if (r[29:28] == 2'd0) begin
                    it.rs2 = it.rs1;
                end
            end
            default: begin
                it.unit = exu_op_pkg::UNIT_MULDIV;
                it.op   = 4'(r[10:8]);
                // most negative over -1
                if (r[26:24] == 3'd0) begin
                    it.rs1 = 32'h8000_0000;
                    it.rs2 = 32'hFFFF_FFFF;
                end
            end
        endcase
        return it;
    endfunction

    function automatic exu_bus_pkg::wb_t model_alu(input exu_bus_pkg::issue_t it);
        exu_bus_pkg::wb_t w;
        int               sa;
        int               sb;
        logic [31:0]      r;
        sa = it.rs1;
        sb = it.rs2;
        case (exu_op_pkg::alu_op_e'(it.op))
            exu_op_pkg::ALU_ADD:  r = 32'(sa + sb);
            exu_op_pkg::ALU_SUB:  r = 32'(sa - sb);
            exu_op_pkg::ALU_AND:  r = it.rs1 & it.rs2;
            exu_op_pkg::ALU_OR:   r = it.rs1 | it.rs2;
            exu_op_pkg::ALU_XOR:  r = it.rs1 ^ it.rs2;
            exu_op_pkg::ALU_SLL:  r = it.rs1 << it.rs2[4:0];
            exu_op_pkg::ALU_SRL:  r = it.rs1 >> it.rs2[4:0];
            exu_op_pkg::ALU_SRA:  r = 32'(sa >>> it.rs2[4:0]);
            exu_op_pkg::ALU_SLT:  r = (sa < sb) ? 32'd1 : 32'd0;
            exu_op_pkg::ALU_SLTU: r = (it.rs1 < it.rs2) ? 32'd1 : 32'd0;
            default:              r = 32'd0;
        endcase
        w.rd        = it.rd;
        w.data      = r;
        w.commit_id = it.commit_id;
        return w;
    endfunction

    function automatic exu_bus_pkg::wb_t model_muldiv(input exu_bus_pkg::issue_t it);
        exu_bus_pkg::wb_t w;
        int               sa;
        int               sb;
        logic [63:0]      p;
        logic [31:0]      r;
        logic             div0;
        logic             ovf;
        sa   = it.rs1;
        sb   = it.rs2;
        div0 = (it.rs2 == 32'd0);
        ovf  = (it.rs1 == 32'h8000_0000) && (it.rs2 == 32'hFFFF_FFFF);
        case (exu_op_pkg::muldiv_op_e'(it.op))
            exu_op_pkg::MD_MUL: begin
                p = longint'(sa) * longint'(sb);
                r = p[31:0];
            end
            exu_op_pkg::MD_MULH: begin
                p = longint'(sa) * longint'(sb);
                r = p[63:32];
            end
            exu_op_pkg::MD_MULHSU: begin
                p = longint'(sa) * longint'({32'd0, it.rs2});
                r = p[63:32];
            end
            exu_op_pkg::MD_MULHU: begin
                p = {32'd0, it.rs1} * {32'd0, it.rs2};
                r = p[63:32];
            end
            exu_op_pkg::MD_DIV:  r = div0 ? 32'hFFFF_FFFF : (ovf ? it.rs1 : 32'(sa / sb));
            exu_op_pkg::MD_DIVU: r = div0 ? 32'hFFFF_FFFF : it.rs1 / it.rs2;
            exu_op_pkg::MD_REM:  r = div0 ? it.rs1 : (ovf ? 32'd0 : 32'(sa % sb));
            default:             r = div0 ? it.rs1 : it.rs1 % it.rs2;
        endcase
        w.rd        = it.rd;
        w.data      = r;
        w.commit_id = it.commit_id;
        return w;
    endfunction

    function automatic exu_bus_pkg::jump_t model_branch(input exu_bus_pkg::issue_t it);
        exu_bus_pkg::jump_t j;
        int                 sa;
        int                 sb;
        logic               t;
        logic [31:0]        sum;
        sa = it.rs1;
        sb = it.rs2;
        case (exu_op_pkg::bru_op_e'(it.op))
            exu_op_pkg::BRU_BEQ:  t = (it.rs1 == it.rs2);
            exu_op_pkg::BRU_BNE:  t = (it.rs1 != it.rs2);
            exu_op_pkg::BRU_BLT:  t = (sa < sb);
            exu_op_pkg::BRU_BGE:  t = (sa >= sb);
            exu_op_pkg::BRU_BLTU: t = (it.rs1 < it.rs2);
            exu_op_pkg::BRU_BGEU: t = (it.rs1 >= it.rs2);
            default:              t = 1'b1;
        endcase
        sum = it.rs1 + it.imm;
        if (!t) begin
            j.target = it.pc + 32'd4;
        end else if (exu_op_pkg::bru_op_e'(it.op) == exu_op_pkg::BRU_JALR) begin
            j.target = {sum[31:1], 1'b0};
        end else begin
            j.target = it.pc + it.imm;
        end
        j.taken      = t;
        j.misaligned = t && j.target[1];
        return j;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_wb(input exu_bus_pkg::wb_t act, input exu_bus_pkg::wb_t exp);
        if (act !== exp) begin
            abort_run($sformatf(
                "FAIL at %0t: wb_o rd=%0d data=%h cid=%0d, expected rd=%0d data=%h cid=%0d",
                $time, act.rd, act.data, act.commit_id, exp.rd, exp.data, exp.commit_id));
        end
    endtask

    task automatic compare_jump(input exu_bus_pkg::jump_t act, input exu_bus_pkg::jump_t exp);
        if (act !== exp) begin
            abort_run($sformatf(
                "FAIL at %0t: jump_o taken=%b mis=%b target=%h, expected taken=%b mis=%b target=%h",
                $time, act.taken, act.misaligned, act.target,
                exp.taken, exp.misaligned, exp.target));
        end
    endtask

    task automatic expect_level(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, act, exp));
        end
    endtask

    // one clock, then new inputs 2 ns after the edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk_i);
        #2;
        r          = next_random();
        wb_ready_i = (r[1:0] != 2'b00);
    endtask

    task automatic send_item(input exu_bus_pkg::issue_t item);
        logic accepted;
        int   waited;
        accepted      = 1'b0;
        waited        = 0;
        issue_i       = item;
        issue_valid_i = 1'b1;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = issue_ready_o;
            next_cycle();
            waited++;
            if (!accepted && waited >= ISSUE_TIMEOUT) begin
                abort_run($sformatf("timeout: issue_ready_o stayed low for %0d cycles", waited));
            end
        end
        issue_valid_i = 1'b0;
        if (item.unit == exu_op_pkg::UNIT_BRU) begin
            jump_expected.push_back(model_branch(item));
        end else if (item.unit == exu_op_pkg::UNIT_MULDIV) begin
            wb_expected.push_back(model_muldiv(item));
        end else begin
            wb_expected.push_back(model_alu(item));
        end
    endtask

    // outputs sampled mid-cycle, where they are stable
    always @(negedge clk_i) begin
        if (arst_n_i && wb_valid_o && wb_ready_i) begin
            if (wb_expected.size() == 0) begin
                abort_run("a writeback came out with no item outstanding");
            end else begin
                compare_wb(wb_o, wb_expected.pop_front());
            end
        end
    end

    always @(negedge clk_i) begin
        if (arst_n_i && jump_valid_o) begin
            if (jump_expected.size() == 0) begin
                abort_run("a jump pulse came out with no branch outstanding");
            end else begin
                compare_jump(jump_o, jump_expected.pop_front());
            end
        end
    end

    initial begin
        exu_bus_pkg::issue_t                item;
        logic [exu_bus_pkg::COMMIT_ID_W-1:0] cid;
        logic [31:0]                        r;
        int                                 waited;
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        wb_ready_i    = 1'b0;
        cid           = '0;
        repeat (2) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        expect_level(wb_valid_o, 1'b0, "wb_valid_o");
        expect_level(jump_valid_o, 1'b0, "jump_valid_o");
        expect_level(issue_ready_o, 1'b1, "issue_ready_o");
        next_cycle();
        for (int n = 0; n < NUM_ITEMS; n++) begin
            item = random_item(cid);
            cid++;
            send_item(item);
            r = next_random();
            if (r[2:0] == 3'd0) begin
                next_cycle();
            end
        end
        waited = 0;
        while ((wb_expected.size() != 0 || jump_expected.size() != 0) &&
               waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (wb_expected.size() == 0 && jump_expected.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("timeout: %0d writebacks and %0d jumps never came out",
                                wb_expected.size(), jump_expected.size()));
        end
    end

endmodule

// File: list.f
source/exu_op_pkg.sv
source/exu_bus_pkg.sv
source/exu_hold_reg.sv
source/exu_dispatch.sv
source/exu_alu.sv
source/exu_bru.sv
source/exu_muldiv.sv
source/exu_writeback.sv
source/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module exu_tb -f list.f -Mdir "$BUILD_DIR" -o exu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/exu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: source/exu_alu.sv
// exu_alu: single-cycle integer ALU producing a writeback record
`timescale 1ns/1ps

module exu_alu (
    input  logic                alu_req_i,
    input  exu_bus_pkg::issue_t head_i,
    output exu_bus_pkg::wb_t    result_o
);
    localparam int XLEN = exu_bus_pkg::XLEN;

    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [4:0]          shamt;
    logic [XLEN-1:0]     res;
    exu_op_pkg::alu_op_e alu_op;

    // operands held at zero between requests so the datapath does not toggle
    assign op_a   = alu_req_i ? head_i.rs1 : '0;
    assign op_b   = alu_req_i ? head_i.rs2 : '0;
    assign shamt  = op_b[4:0];
    assign alu_op = exu_op_pkg::alu_op_e'(head_i.op);

    always_comb begin
        case (alu_op)
            exu_op_pkg::ALU_ADD:  res = op_a + op_b;
            exu_op_pkg::ALU_SUB:  res = op_a - op_b;
            exu_op_pkg::ALU_AND:  res = op_a & op_b;
            exu_op_pkg::ALU_OR:   res = op_a | op_b;
            exu_op_pkg::ALU_XOR:  res = op_a ^ op_b;
            exu_op_pkg::ALU_SLL:  res = op_a << shamt;
            exu_op_pkg::ALU_SRL:  res = op_a >> shamt;
            exu_op_pkg::ALU_SRA:  res = $signed(op_a) >>> shamt;
            exu_op_pkg::ALU_SLT: begin
                res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            exu_op_pkg::ALU_SLTU: begin
                res = {{(XLEN-1){1'b0}}, op_a < op_b};
            end
            default:              res = '0;
        endcase
    end

    always_comb begin
        result_o.rd        = head_i.rd;
        result_o.data      = res;
        result_o.commit_id = head_i.commit_id;
    end

endmodule

// File: source/exu_bru.sv
// exu_bru: branch compare, jump target and registered jump pulse
`timescale 1ns/1ps

module exu_bru (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                bru_req_i,
    input  exu_bus_pkg::issue_t head_i,
    output logic                jump_valid_o,
    output exu_bus_pkg::jump_t  jump_o
);
    localparam int XLEN = exu_bus_pkg::XLEN;

    exu_op_pkg::bru_op_e bru_op;
    logic                taken;
    logic [XLEN-1:0]     target;
    logic                jump_valid_q;
    exu_bus_pkg::jump_t  jump_q;

    assign bru_op = exu_op_pkg::bru_op_e'(head_i.op);

    always_comb begin
        case (bru_op)
            exu_op_pkg::BRU_BEQ:  taken = (head_i.rs1 == head_i.rs2);
            exu_op_pkg::BRU_BNE:  taken = (head_i.rs1 != head_i.rs2);
            exu_op_pkg::BRU_BLT:  taken = ($signed(head_i.rs1) < $signed(head_i.rs2));
            exu_op_pkg::BRU_BGE:  taken = ($signed(head_i.rs1) >= $signed(head_i.rs2));
            exu_op_pkg::BRU_BLTU: taken = (head_i.rs1 < head_i.rs2);
            exu_op_pkg::BRU_BGEU: taken = (head_i.rs1 >= head_i.rs2);
            exu_op_pkg::BRU_JAL,
            exu_op_pkg::BRU_JALR: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    // jalr drops bit 0, a fall-through goes to the next instruction
    always_comb begin
        if (!taken) begin
            target = head_i.pc + XLEN'(4);
        end else if (bru_op == exu_op_pkg::BRU_JALR) begin
            target = (head_i.rs1 + head_i.imm) & ~XLEN'(1);
        end else begin
            target = head_i.pc + head_i.imm;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            jump_valid_q <= 1'b0;
        end else begin
            jump_valid_q <= bru_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bru_req_i) begin
            jump_q.taken      <= taken;
            jump_q.misaligned <= taken && target[1];
            jump_q.target     <= target;
        end
    end

    assign jump_valid_o = jump_valid_q;
    assign jump_o       = jump_q;

endmodule

// File: source/exu_bus_pkg.sv
// data widths and the issue, writeback and jump records
package exu_bus_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // one issued instruction, operands already read
    typedef struct packed {
        exu_op_pkg::unit_e      unit;
        exu_op_pkg::op_t        op;
        logic [XLEN-1:0]        rs1;
        // holds the immediate for immediate forms of ALU ops
        logic [XLEN-1:0]        rs2;
        logic [XLEN-1:0]        pc;
        logic [XLEN-1:0]        imm;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } issue_t;

    // register writeback record
    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        data;
        logic [COMMIT_ID_W-1:0] commit_id;
    } wb_t;

    // branch outcome sent to fetch
    typedef struct packed {
        logic            taken;
        logic            misaligned;
        logic [XLEN-1:0] target;
    } jump_t;

endpackage

// File: source/exu_dispatch.sv
// exu_dispatch: issue register and in-order release of the head item to the units
`timescale 1ns/1ps

module exu_dispatch (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    output logic                issue_ready_o,
    input  exu_bus_pkg::issue_t issue_i,
    input  logic                wb_space_i,
    input  logic                muldiv_busy_i,
    output exu_bus_pkg::issue_t head_o,
    output logic                alu_req_o,
    output logic                bru_req_o,
    output logic                muldiv_start_o
);
    logic                head_valid;
    logic                head_release;
    logic                head_is_bru;
    logic                head_is_muldiv;
    logic                head_is_alu;
    exu_bus_pkg::issue_t head;

    exu_hold_reg #(
        .payload_t(exu_bus_pkg::issue_t)
    ) u_issue_reg (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (issue_valid_i),
        .in_ready_o (issue_ready_o),
        .in_data_i  (issue_i),
        .out_valid_o(head_valid),
        .out_ready_i(head_release),
        .out_data_o (head)
    );

    // unknown unit codes fall through to the ALU so every pop raises one request
    assign head_is_bru    = (head.unit == exu_op_pkg::UNIT_BRU);
    assign head_is_muldiv = (head.unit == exu_op_pkg::UNIT_MULDIV);
    assign head_is_alu    = !head_is_bru && !head_is_muldiv;

    // muldiv busy covers a pending result as well, which keeps issue order
    always_comb begin
        head_release = 1'b0;
        if (head_valid && !muldiv_busy_i) begin
            head_release = head_is_alu ? wb_space_i : 1'b1;
        end
    end

    assign alu_req_o      = head_release && head_is_alu;
    assign bru_req_o      = head_release && head_is_bru;
    assign muldiv_start_o = head_release && head_is_muldiv;
    assign head_o         = head;

endmodule

// File: source/exu_hold_reg.sv
// exu_hold_reg: one-entry valid/ready pipeline register with a typed payload
`timescale 1ns/1ps

module exu_hold_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);
    logic     valid_q;
    payload_t data_q;

    // accept when empty or when the current item leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

// File: source/exu_muldiv.sv
// exu_muldiv: iterative shift-add multiplier and restoring divider
`timescale 1ns/1ps

module exu_muldiv (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                start_i,
    input  exu_bus_pkg::issue_t head_i,
    output logic                busy_o,
    output logic                done_o,
    output exu_bus_pkg::wb_t    result_o,
    input  logic                take_i
);
    localparam int XLEN  = exu_bus_pkg::XLEN;
    localparam int CNT_W = $clog2(XLEN);

    exu_op_pkg::muldiv_op_e start_op;
    logic                   a_signed;
    logic                   b_signed;
    logic                   a_neg;
    logic                   b_neg;
    logic [XLEN-1:0]        mag_a;
    logic [XLEN-1:0]        mag_b;

    logic                   busy_q;
    logic                   done_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   running;

    // acc holds hi:lo of the product, or remainder:quotient while dividing
    logic [2*XLEN-1:0]      acc_q;
    logic [XLEN-1:0]        opb_q;
    exu_op_pkg::muldiv_op_e op_q;
    logic                   neg_q;
    logic                   rneg_q;
    logic                   div0_q;
    logic [XLEN-1:0]        dividend_q;
    logic [exu_bus_pkg::REG_ADDR_W-1:0]  rd_q;
    logic [exu_bus_pkg::COMMIT_ID_W-1:0] cid_q;

    logic                   op_is_div;
    logic [XLEN:0]          mul_sum;
    logic [2*XLEN-1:0]      mul_next;
    logic [XLEN:0]          rem_shift;
    logic [XLEN:0]          div_diff;
    logic [2*XLEN-1:0]      div_next;
    logic [2*XLEN-1:0]      prod;
    logic [XLEN-1:0]        quot;
    logic [XLEN-1:0]        rem;
    logic [XLEN-1:0]        res_data;

    assign start_op = exu_op_pkg::muldiv_op_e'(head_i.op);

    always_comb begin
        a_signed = 1'b0;
        b_signed = 1'b0;
        case (start_op)
            exu_op_pkg::MD_MULH,
            exu_op_pkg::MD_DIV,
            exu_op_pkg::MD_REM: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            exu_op_pkg::MD_MULHSU: a_signed = 1'b1;
            default: ;
        endcase
    end

    // work on magnitudes, signs are applied once at the end
    assign a_neg = a_signed && head_i.rs1[XLEN-1];
    assign b_neg = b_signed && head_i.rs2[XLEN-1];
    assign mag_a = a_neg ? -head_i.rs1 : head_i.rs1;
    assign mag_b = b_neg ? -head_i.rs2 : head_i.rs2;

    assign running   = busy_q && !done_q;
    assign op_is_div = op_q inside {exu_op_pkg::MD_DIV, exu_op_pkg::MD_DIVU,
                                    exu_op_pkg::MD_REM, exu_op_pkg::MD_REMU};

    // add the multiplicand on a set lsb, then shift the pair right
    assign mul_sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, opb_q} : '0);
    assign mul_next = {mul_sum, acc_q[XLEN-1:1]};

    // shift in the next dividend bit and keep the difference if it fits
    assign rem_shift = {acc_q[2*XLEN-1:XLEN], acc_q[XLEN-1]};
    assign div_diff  = rem_shift - {1'b0, opb_q};
    assign div_next  = div_diff[XLEN] ? {rem_shift[XLEN-1:0], acc_q[XLEN-2:0], 1'b0}
                                      : {div_diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (take_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (running) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(XLEN - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q      <= {{XLEN{1'b0}}, mag_a};
            opb_q      <= mag_b;
            op_q       <= start_op;
            neg_q      <= a_neg ^ b_neg;
            rneg_q     <= a_neg;
            div0_q     <= (head_i.rs2 == '0);
            dividend_q <= head_i.rs1;
            rd_q       <= head_i.rd;
            cid_q      <= head_i.commit_id;
        end else if (running) begin
            acc_q <= op_is_div ? div_next : mul_next;
        end
    end

    // most negative / -1 falls out of the magnitude path unchanged
    assign prod = neg_q ? -acc_q : acc_q;
    assign quot = neg_q ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    assign rem  = rneg_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    always_comb begin
        case (op_q)
            exu_op_pkg::MD_MUL:  res_data = prod[XLEN-1:0];
            exu_op_pkg::MD_MULH,
            exu_op_pkg::MD_MULHSU,
            exu_op_pkg::MD_MULHU: res_data = prod[2*XLEN-1:XLEN];
            exu_op_pkg::MD_DIV,
            exu_op_pkg::MD_DIVU: res_data = div0_q ? '1 : quot;
            default:             res_data = div0_q ? dividend_q : rem;
        endcase
    end

    always_comb begin
        result_o.rd        = rd_q;
        result_o.data      = res_data;
        result_o.commit_id = cid_q;
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// File: source/exu_op_pkg.sv
// operation encodings: unit select, ALU ops, branch ops, multiply/divide ops
package exu_op_pkg;

    // execution unit selected by the issue slot
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRU    = 2'd1,
        UNIT_MULDIV = 2'd2
    } unit_e;

    // raw op field, read through the enum of the selected unit
    typedef logic [3:0] op_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        BRU_BEQ  = 4'd0,
        BRU_BNE  = 4'd1,
        BRU_BLT  = 4'd2,
        BRU_BGE  = 4'd3,
        BRU_BLTU = 4'd4,
        BRU_BGEU = 4'd5,
        BRU_JAL  = 4'd6,
        BRU_JALR = 4'd7
    } bru_op_e;

    // mul group first, div group in the upper half
    typedef enum logic [3:0] {
        MD_MUL    = 4'd0,
        MD_MULH   = 4'd1,
        MD_MULHSU = 4'd2,
        MD_MULHU  = 4'd3,
        MD_DIV    = 4'd4,
        MD_DIVU   = 4'd5,
        MD_REM    = 4'd6,
        MD_REMU   = 4'd7
    } muldiv_op_e;

endpackage

// File: source/exu_top.sv
// exu_top: execute stage with dispatch, ALU, branch unit, muldiv and writeback
`timescale 1ns/1ps

module exu_top (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    output logic                issue_ready_o,
    input  exu_bus_pkg::issue_t issue_i,
    output logic                wb_valid_o,
    input  logic                wb_ready_i,
    output exu_bus_pkg::wb_t    wb_o,
    output logic                jump_valid_o,
    output exu_bus_pkg::jump_t  jump_o
);
    exu_bus_pkg::issue_t head;
    logic                alu_req;
    logic                bru_req;
    logic                muldiv_start;
    logic                muldiv_busy;
    logic                muldiv_done;
    logic                muldiv_take;
    logic                wb_space;
    exu_bus_pkg::wb_t    alu_result;
    exu_bus_pkg::wb_t    muldiv_result;

    exu_dispatch u_dispatch (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .wb_space_i    (wb_space),
        .muldiv_busy_i (muldiv_busy),
        .head_o        (head),
        .alu_req_o     (alu_req),
        .bru_req_o     (bru_req),
        .muldiv_start_o(muldiv_start)
    );

    exu_alu u_alu (
        .alu_req_i(alu_req),
        .head_i   (head),
        .result_o (alu_result)
    );

    exu_bru u_bru (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .bru_req_i   (bru_req),
        .head_i      (head),
        .jump_valid_o(jump_valid_o),
        .jump_o      (jump_o)
    );

    exu_muldiv u_muldiv (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .start_i (muldiv_start),
        .head_i  (head),
        .busy_o  (muldiv_busy),
        .done_o  (muldiv_done),
        .result_o(muldiv_result),
        .take_i  (muldiv_take)
    );

    exu_writeback u_writeback (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .alu_valid_i    (alu_req),
        .alu_result_i   (alu_result),
        .muldiv_done_i  (muldiv_done),
        .muldiv_result_i(muldiv_result),
        .muldiv_take_o  (muldiv_take),
        .space_o        (wb_space),
        .wb_valid_o     (wb_valid_o),
        .wb_ready_i     (wb_ready_i),
        .wb_o           (wb_o)
    );

endmodule

// File: source/exu_writeback.sv
// exu_writeback: merges ALU and muldiv records into the writeback register
`timescale 1ns/1ps

module exu_writeback (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             alu_valid_i,
    input  exu_bus_pkg::wb_t alu_result_i,
    input  logic             muldiv_done_i,
    input  exu_bus_pkg::wb_t muldiv_result_i,
    output logic             muldiv_take_o,
    output logic             space_o,
    output logic             wb_valid_o,
    input  logic             wb_ready_i,
    output exu_bus_pkg::wb_t wb_o
);
    logic             load_valid;
    exu_bus_pkg::wb_t load_data;

    // ALU first; dispatch never lets both arrive together
    assign load_valid    = alu_valid_i || muldiv_done_i;
    assign load_data     = alu_valid_i ? alu_result_i : muldiv_result_i;
    assign muldiv_take_o = muldiv_done_i && !alu_valid_i && space_o;

    exu_hold_reg #(
        .payload_t(exu_bus_pkg::wb_t)
    ) u_wb_reg (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (load_valid),
        .in_ready_o (space_o),
        .in_data_i  (load_data),
        .out_valid_o(wb_valid_o),
        .out_ready_i(wb_ready_i),
        .out_data_o (wb_o)
    );

endmodule
